/* verilog/rv_decode_pkg.sv */
// shared widths and encodings for the RV32IM decode stage
// only 32-bit instructions are recognised, compressed opcodes are illegal

`default_nettype none

package rv_decode_pkg;

	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;
	localparam int W_REGADDR = 5;

	// every instruction is one word, so the PC always steps by this
	localparam int unsigned INSTR_BYTES = 4;

	// ----------------------------------------------------------
	// major opcodes, instruction bits 6:2

	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011,
		OPC_SYSTEM   = 5'b11100
	} opcode_e;

	// full encodings of the SYSTEM instructions that decode accepts
	localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;

	// ----------------------------------------------------------
	// execute stage controls

	typedef enum logic [3:0] {
		ALUOP_ADD    = 4'h0,
		ALUOP_SUB    = 4'h1,
		ALUOP_SLL    = 4'h2,
		ALUOP_LT     = 4'h3,
		ALUOP_LTU    = 4'h4,
		ALUOP_XOR    = 4'h5,
		ALUOP_SRL    = 4'h6,
		ALUOP_SRA    = 4'h7,
		ALUOP_OR     = 4'h8,
		ALUOP_AND    = 4'h9,
		ALUOP_RS2    = 4'ha,
		ALUOP_MULDIV = 4'hb
	} aluop_e;

	typedef enum logic {ALUSRCA_RS1 = 1'b0, ALUSRCA_PC  = 1'b1} alusrc_a_e;
	typedef enum logic {ALUSRCB_RS2 = 1'b0, ALUSRCB_IMM = 1'b1} alusrc_b_e;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'h0,
		MEMOP_LB   = 4'h1,
		MEMOP_LH   = 4'h2,
		MEMOP_LW   = 4'h3,
		MEMOP_LBU  = 4'h4,
		MEMOP_LHU  = 4'h5,
		MEMOP_SB   = 4'h6,
		MEMOP_SH   = 4'h7,
		MEMOP_SW   = 4'h8
	} memop_e;

	// ordered as funct3 of the M extension so decode can take it directly
	typedef enum logic [2:0] {
		M_OP_MUL, M_OP_MULH, M_OP_MULHSU, M_OP_MULHU,
		M_OP_DIV, M_OP_DIVU, M_OP_REM, M_OP_REMU
	} mulop_e;

	typedef enum logic [1:0] {
		BCOND_NEVER  = 2'b00,
		BCOND_ZERO   = 2'b01,
		BCOND_NZERO  = 2'b10,
		BCOND_ALWAYS = 2'b11
	} bcond_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE          = 3'h0,
		EXCEPT_INSTR_FAULT   = 3'h1,
		EXCEPT_INSTR_ILLEGAL = 3'h2,
		EXCEPT_ECALL_M       = 3'h3,
		EXCEPT_ECALL_U       = 3'h4,
		EXCEPT_EBREAK        = 3'h5,
		EXCEPT_MRET          = 3'h6
	} except_e;

endpackage

`default_nettype wire

/* verilog/rv_imm_gen.sv */
// immediate extraction for 32-bit RISC-V formats
// addr_offs_o is zero for classes that form no address

`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_decode_pkg::*; (
	input  logic [31:0]       instr_i,
	input  opcode_e           opcode_class_i,
	output logic [W_DATA-1:0] imm_i_o,
	output logic [W_DATA-1:0] imm_u_o,
	output logic [W_ADDR-1:0] addr_offs_o
);

	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_s;
	logic [W_DATA-1:0] imm_b;
	logic [W_DATA-1:0] imm_u;
	logic [W_DATA-1:0] imm_j;

	// all formats take their sign from bit 31
	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	assign imm_i_o = imm_i;
	assign imm_u_o = imm_u;

	// offset added to PC (jumps, branches) or to rs1 (JALR, loads, stores)
	always_comb begin
		case (opcode_class_i)
			OPC_JAL:    addr_offs_o = imm_j;
			OPC_BRANCH: addr_offs_o = imm_b;
			OPC_STORE:  addr_offs_o = imm_s;
			OPC_JALR:   addr_offs_o = imm_i;
			OPC_LOAD:   addr_offs_o = imm_i;
			default:    addr_offs_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rv_op_decode.sv */
// RV32I/M instruction table with kill and exception overrides
// a starved, faulting or invalid instruction never reaches execute as a real op

`timescale 1ns/1ps
`default_nettype none

module rv_op_decode import rv_decode_pkg::*; #(
	parameter bit EXTENSION_M = 1'b1
) (
	input  logic [31:0]          instr_i,
	input  logic                 m_mode_i,
	input  logic                 starved_i,
	input  logic                 fetch_fault_i,
	input  logic                 cir_locked_i,
	input  logic [W_DATA-1:0]    imm_i_i,
	input  logic [W_DATA-1:0]    imm_u_i,
	output opcode_e              opcode_class_o,
	output logic [W_REGADDR-1:0] rs1_o,
	output logic [W_REGADDR-1:0] rs2_o,
	output logic [W_REGADDR-1:0] rd_o,
	output logic [W_DATA-1:0]    imm_o,
	output logic [2:0]           funct3_o,
	output logic [6:0]           funct7_o,
	output alusrc_a_e            alusrc_a_o,
	output alusrc_b_e            alusrc_b_o,
	output aluop_e               aluop_o,
	output memop_e               memop_o,
	output mulop_e               mulop_o,
	output bcond_e               branchcond_o,
	output logic                 addr_is_regoffs_o,
	output except_e              except_o
);

	localparam logic [W_REGADDR-1:0] X0 = '0;
	localparam logic [6:0] F7_BASE = 7'b000_0000;
	localparam logic [6:0] F7_ALT  = 7'b010_0000;
	localparam logic [6:0] F7_MUL  = 7'b000_0001;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       invalid;

	assign funct3         = instr_i[14:12];
	assign funct7         = instr_i[31:25];
	assign opcode_class_o = opcode_e'(instr_i[6:2]);
	assign funct3_o       = funct3;
	assign funct7_o       = funct7;

	always_comb begin
		rs1_o             = instr_i[19:15];
		rs2_o             = instr_i[24:20];
		rd_o              = instr_i[11:7];
		imm_o             = imm_i_i;
		alusrc_a_o        = ALUSRCA_RS1;
		alusrc_b_o        = ALUSRCB_RS2;
		aluop_o           = ALUOP_ADD;
		memop_o           = MEMOP_NONE;
		mulop_o           = M_OP_MUL;
		branchcond_o      = BCOND_NEVER;
		addr_is_regoffs_o = 1'b0;
		except_o          = EXCEPT_NONE;
		// the two low bits mark a 32-bit encoding, anything else is not ours
		invalid           = instr_i[1:0] != 2'b11;

		case (opcode_class_o)
			OPC_BRANCH: begin
				rd_o = X0;
				case (funct3)
					3'b000: begin aluop_o = ALUOP_SUB; branchcond_o = BCOND_ZERO;  end
					3'b001: begin aluop_o = ALUOP_SUB; branchcond_o = BCOND_NZERO; end
					3'b100: begin aluop_o = ALUOP_LT;  branchcond_o = BCOND_NZERO; end
					3'b101: begin aluop_o = ALUOP_LT;  branchcond_o = BCOND_ZERO;  end
					3'b110: begin aluop_o = ALUOP_LTU; branchcond_o = BCOND_NZERO; end
					3'b111: begin aluop_o = ALUOP_LTU; branchcond_o = BCOND_ZERO;  end
					default: invalid = 1'b1;
				endcase
			end
			// jumps compute the link value PC + 4 in the ALU
			OPC_JAL, OPC_JALR: begin
				branchcond_o = BCOND_ALWAYS;
				alusrc_a_o   = ALUSRCA_PC;
				alusrc_b_o   = ALUSRCB_IMM;
				imm_o        = W_DATA'(INSTR_BYTES);
				rs2_o        = X0;
				if (opcode_class_o == OPC_JAL) begin
					rs1_o = X0;
				end else begin
					addr_is_regoffs_o = 1'b1;
					invalid           = invalid || funct3 != 3'b000;
				end
			end
			OPC_LUI, OPC_AUIPC: begin
				imm_o      = imm_u_i;
				alusrc_b_o = ALUSRCB_IMM;
				rs1_o      = X0;
				rs2_o      = X0;
				if (opcode_class_o == OPC_LUI)
					aluop_o = ALUOP_RS2;
				else
					alusrc_a_o = ALUSRCA_PC;
			end
			OPC_LOAD: begin
				addr_is_regoffs_o = 1'b1;
				rs2_o             = X0;
				case (funct3)
					3'b000:  memop_o = MEMOP_LB;
					3'b001:  memop_o = MEMOP_LH;
					3'b010:  memop_o = MEMOP_LW;
					3'b100:  memop_o = MEMOP_LBU;
					3'b101:  memop_o = MEMOP_LHU;
					default: invalid = 1'b1;
				endcase
			end
			// store data passes through the ALU as rs2
			OPC_STORE: begin
				addr_is_regoffs_o = 1'b1;
				aluop_o           = ALUOP_RS2;
				rd_o              = X0;
				case (funct3)
					3'b000:  memop_o = MEMOP_SB;
					3'b001:  memop_o = MEMOP_SH;
					3'b010:  memop_o = MEMOP_SW;
					default: invalid = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				imm_o      = imm_i_i;
				alusrc_b_o = ALUSRCB_IMM;
				rs2_o      = X0;
				case (funct3)
					3'b000: aluop_o = ALUOP_ADD;
					3'b010: aluop_o = ALUOP_LT;
					3'b011: aluop_o = ALUOP_LTU;
					3'b100: aluop_o = ALUOP_XOR;
					3'b110: aluop_o = ALUOP_OR;
					3'b111: aluop_o = ALUOP_AND;
					3'b001: begin
						aluop_o = ALUOP_SLL;
						invalid = invalid || funct7 != F7_BASE;
					end
					default: begin
						aluop_o = funct7 == F7_ALT ? ALUOP_SRA : ALUOP_SRL;
						invalid = invalid || (funct7 != F7_BASE && funct7 != F7_ALT);
					end
				endcase
			end
			OPC_OP: begin
				if (funct7 == F7_BASE) begin
					case (funct3)
						3'b000: aluop_o = ALUOP_ADD;
						3'b001: aluop_o = ALUOP_SLL;
						3'b010: aluop_o = ALUOP_LT;
						3'b011: aluop_o = ALUOP_LTU;
						3'b100: aluop_o = ALUOP_XOR;
						3'b101: aluop_o = ALUOP_SRL;
						3'b110: aluop_o = ALUOP_OR;
						default: aluop_o = ALUOP_AND;
					endcase
				end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
					aluop_o = ALUOP_SUB;
				end else if (funct7 == F7_ALT && funct3 == 3'b101) begin
					aluop_o = ALUOP_SRA;
				end else if (funct7 == F7_MUL && EXTENSION_M) begin
					aluop_o = ALUOP_MULDIV;
					mulop_o = mulop_e'(funct3);
				end else begin
					invalid = 1'b1;
				end
			end
			// FENCE has nothing to order in this core
			OPC_MISC_MEM: begin
				rs2_o   = X0;
				invalid = invalid || funct3 != 3'b000;
			end
			OPC_SYSTEM: begin
				rs1_o = X0;
				rs2_o = X0;
				rd_o  = X0;
				if (instr_i == INSTR_ECALL)
					except_o = m_mode_i ? EXCEPT_ECALL_M : EXCEPT_ECALL_U;
				else if (instr_i == INSTR_EBREAK)
					except_o = EXCEPT_EBREAK;
				else if (instr_i == INSTR_MRET && m_mode_i)
					except_o = EXCEPT_MRET;
				else
					invalid = 1'b1;
			end
			default: invalid = 1'b1;
		endcase

		// ----------------------------------------------------------
		// kill: turn the slot into a harmless add with no side effects
		if (invalid || starved_i || fetch_fault_i) begin
			rs1_o             = X0;
			rs2_o             = X0;
			rd_o              = X0;
			memop_o           = MEMOP_NONE;
			branchcond_o      = BCOND_NEVER;
			addr_is_regoffs_o = 1'b1;
			aluop_o           = ALUOP_ADD;
			except_o          = EXCEPT_NONE;
			// a fetch fault outranks whatever the garbage word decodes to
			if (fetch_fault_i)
				except_o = EXCEPT_INSTR_FAULT;
			else if (invalid && !starved_i)
				except_o = EXCEPT_INSTR_ILLEGAL;
		end
		// the jump of a locked instruction was already taken
		if (cir_locked_i)
			branchcond_o = BCOND_NEVER;
	end

endmodule

`default_nettype wire

/* verilog/rv_pc_ctrl.sv */
// PC register, CIR consumption and CIR lock for 32-bit-only fetch
// the frontend must hold f_jump_target_i stable while a lock is held

`timescale 1ns/1ps
`default_nettype none

module rv_pc_ctrl import rv_decode_pkg::*; #(
	parameter logic [W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [1:0]        fd_cir_vld_i,
	input  logic [1:0]        fd_cir_err_i,
	input  logic              x_stall_i,
	input  logic              f_jump_now_i,
	input  logic [W_ADDR-1:0] f_jump_target_i,
	input  logic              x_jump_not_except_i,
	output logic [W_ADDR-1:0] d_pc_o,
	output logic [1:0]        df_cir_use_o,
	output logic              df_cir_flush_behind_o,
	output logic              starved_o,
	output logic              fetch_fault_o,
	output logic              cir_locked_o
);

	logic              d_stall;
	logic              jump_caused_by_d;
	logic              assert_cir_lock;
	logic              cir_lock;
	logic              cir_lock_prev;
	logic              update_pc_on_unlock;
	logic [W_ADDR-1:0] pc;

	// ----------------------------------------------------------
	// CIR state

	// a whole instruction needs both halfwords
	assign starved_o     = fd_cir_vld_i < 2'd2;
	assign fetch_fault_o = !starved_o && |fd_cir_err_i;
	assign d_stall       = x_stall_i || starved_o;
	assign df_cir_use_o  = d_stall ? 2'd0 : 2'd2;

	// ----------------------------------------------------------
	// CIR lock

	// a jump granted while decode is stalled cannot be withdrawn, so the
	// frontend keeps the stalled instruction and refills behind it; the
	// instruction finishes its remaining work (the link write) once the
	// stall clears
	assign jump_caused_by_d      = f_jump_now_i && x_jump_not_except_i;
	assign assert_cir_lock       = jump_caused_by_d && d_stall;
	assign cir_lock              = (cir_lock_prev && d_stall) || assert_cir_lock;
	assign df_cir_flush_behind_o = assert_cir_lock && !cir_lock_prev;
	assign cir_locked_o          = cir_lock_prev;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cir_lock_prev <= 1'b0;
		end else begin
			cir_lock_prev <= cir_lock;
		end
	end

	// ----------------------------------------------------------
	// program counter

	// the target presented in the release cycle is the one to follow
	assign update_pc_on_unlock = cir_lock_prev && !d_stall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_VECTOR;
		end else if ((f_jump_now_i && !assert_cir_lock) || update_pc_on_unlock) begin
			// traps still redirect during a stall, only decode jumps wait
			pc <= f_jump_target_i;
		end else if (!d_stall && !cir_lock) begin
			pc <= pc + W_ADDR'(INSTR_BYTES);
		end
	end

	assign d_pc_o = pc;

endmodule

`default_nettype wire

/* verilog/rv_decode_top.sv */
// decode stage of a 32-bit RISC-V core, RV32I with optional M
// all decode outputs are combinational from the CIR, only PC and lock are state

`timescale 1ns/1ps
`default_nettype none

module rv_decode_top import rv_decode_pkg::*; #(
	parameter logic [W_ADDR-1:0] RESET_VECTOR = '0,
	parameter bit                EXTENSION_M  = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// frontend
	input  logic [31:0]          fd_cir_i,
	input  logic [1:0]           fd_cir_vld_i,
	input  logic [1:0]           fd_cir_err_i,
	output logic [1:0]           df_cir_use_o,
	output logic                 df_cir_flush_behind_o,
	output logic [W_ADDR-1:0]    d_pc_o,
	input  logic                 f_jump_now_i,
	input  logic [W_ADDR-1:0]    f_jump_target_i,

	// execute and machine state
	input  logic                 m_mode_i,
	input  logic                 x_stall_i,
	input  logic                 x_jump_not_except_i,
	output logic                 d_starved_o,

	// execute controls
	output logic [W_DATA-1:0]    d_imm_o,
	output logic [W_REGADDR-1:0] d_rs1_o,
	output logic [W_REGADDR-1:0] d_rs2_o,
	output logic [W_REGADDR-1:0] d_rd_o,
	output logic [2:0]           d_funct3_o,
	output logic [6:0]           d_funct7_o,
	output alusrc_a_e            d_alusrc_a_o,
	output alusrc_b_e            d_alusrc_b_o,
	output aluop_e               d_aluop_o,
	output memop_e               d_memop_o,
	output mulop_e               d_mulop_o,
	output bcond_e               d_branchcond_o,
	output logic [W_ADDR-1:0]    d_addr_offs_o,
	output logic                 d_addr_is_regoffs_o,
	output except_e              d_except_o
);

	logic              starved;
	logic              fetch_fault;
	logic              cir_locked;
	opcode_e           opcode_class;
	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_u;

	assign d_starved_o = starved;

	rv_pc_ctrl #(
		.RESET_VECTOR (RESET_VECTOR)
	) pc_ctrl_i (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.fd_cir_vld_i          (fd_cir_vld_i),
		.fd_cir_err_i          (fd_cir_err_i),
		.x_stall_i             (x_stall_i),
		.f_jump_now_i          (f_jump_now_i),
		.f_jump_target_i       (f_jump_target_i),
		.x_jump_not_except_i   (x_jump_not_except_i),
		.d_pc_o                (d_pc_o),
		.df_cir_use_o          (df_cir_use_o),
		.df_cir_flush_behind_o (df_cir_flush_behind_o),
		.starved_o             (starved),
		.fetch_fault_o         (fetch_fault),
		.cir_locked_o          (cir_locked)
	);

	rv_imm_gen imm_gen_i (
		.instr_i        (fd_cir_i),
		.opcode_class_i (opcode_class),
		.imm_i_o        (imm_i),
		.imm_u_o        (imm_u),
		.addr_offs_o    (d_addr_offs_o)
	);

	rv_op_decode #(
		.EXTENSION_M (EXTENSION_M)
	) op_decode_i (
		.instr_i           (fd_cir_i),
		.m_mode_i          (m_mode_i),
		.starved_i         (starved),
		.fetch_fault_i     (fetch_fault),
		.cir_locked_i      (cir_locked),
		.imm_i_i           (imm_i),
		.imm_u_i           (imm_u),
		.opcode_class_o    (opcode_class),
		.rs1_o             (d_rs1_o),
		.rs2_o             (d_rs2_o),
		.rd_o              (d_rd_o),
		.imm_o             (d_imm_o),
		.funct3_o          (d_funct3_o),
		.funct7_o          (d_funct7_o),
		.alusrc_a_o        (d_alusrc_a_o),
		.alusrc_b_o        (d_alusrc_b_o),
		.aluop_o           (d_aluop_o),
		.memop_o           (d_memop_o),
		.mulop_o           (d_mulop_o),
		.branchcond_o      (d_branchcond_o),
		.addr_is_regoffs_o (d_addr_is_regoffs_o),
		.except_o          (d_except_o)
	);

endmodule

`default_nettype wire

/* dv/tb_rv_decode.sv */
// testbench for the RV32IM decode stage, built with EXTENSION_M set
// inputs change on the rising edge, all outputs are checked at the falling edge

`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode import rv_decode_pkg::*;;

	localparam logic [31:0] RESET_VECTOR    = 32'h0000_0100;
	localparam int          RELEASE_TIMEOUT = 8;
	localparam logic [31:0] NOP             = 32'h0000_0013;
	// beq x1, x2, +8
	localparam logic [31:0] BEQ_FWD         = 32'h0020_8463;

	logic                 clk;
	logic                 rst_n;
	logic [31:0]          fd_cir_i;
	logic [1:0]           fd_cir_vld_i;
	logic [1:0]           fd_cir_err_i;
	logic                 f_jump_now_i;
	logic [31:0]          f_jump_target_i;
	logic                 m_mode_i;
	logic                 x_stall_i;
	logic                 x_jump_not_except_i;
	logic [1:0]           df_cir_use_o;
	logic                 df_cir_flush_behind_o;
	logic [31:0]          d_pc_o;
	logic                 d_starved_o;
	logic [31:0]          d_imm_o;
	logic [4:0]           d_rs1_o;
	logic [4:0]           d_rs2_o;
	logic [4:0]           d_rd_o;
	logic [2:0]           d_funct3_o;
	logic [6:0]           d_funct7_o;
	alusrc_a_e            d_alusrc_a_o;
	alusrc_b_e            d_alusrc_b_o;
	aluop_e               d_aluop_o;
	memop_e               d_memop_o;
	mulop_e               d_mulop_o;
	bcond_e               d_branchcond_o;
	logic [31:0]          d_addr_offs_o;
	logic                 d_addr_is_regoffs_o;
	except_e              d_except_o;

	// reference model state
	logic [31:0] exp_pc;
	logic        exp_lock;
	logic [31:0] lcg_state;
	int          mismatch_count;
	int          timeout_count;

	// expected decode outputs, filled in by ref_decode
	logic [4:0]  exp_rs1;
	logic [4:0]  exp_rs2;
	logic [4:0]  exp_rd;
	logic [31:0] exp_imm;
	logic [31:0] exp_offs;
	alusrc_a_e   exp_src_a;
	alusrc_b_e   exp_src_b;
	aluop_e      exp_aluop;
	memop_e      exp_memop;
	mulop_e      exp_mulop;
	bcond_e      exp_bcond;
	logic        exp_regoffs;
	except_e     exp_except;

	rv_decode_top #(
		.RESET_VECTOR (RESET_VECTOR),
		.EXTENSION_M  (1'b1)
	) dut_i (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.fd_cir_i              (fd_cir_i),
		.fd_cir_vld_i          (fd_cir_vld_i),
		.fd_cir_err_i          (fd_cir_err_i),
		.df_cir_use_o          (df_cir_use_o),
		.df_cir_flush_behind_o (df_cir_flush_behind_o),
		.d_pc_o                (d_pc_o),
		.f_jump_now_i          (f_jump_now_i),
		.f_jump_target_i       (f_jump_target_i),
		.m_mode_i              (m_mode_i),
		.x_stall_i             (x_stall_i),
		.x_jump_not_except_i   (x_jump_not_except_i),
		.d_starved_o           (d_starved_o),
		.d_imm_o               (d_imm_o),
		.d_rs1_o               (d_rs1_o),
		.d_rs2_o               (d_rs2_o),
		.d_rd_o                (d_rd_o),
		.d_funct3_o            (d_funct3_o),
		.d_funct7_o            (d_funct7_o),
		.d_alusrc_a_o          (d_alusrc_a_o),
		.d_alusrc_b_o          (d_alusrc_b_o),
		.d_aluop_o             (d_aluop_o),
		.d_memop_o             (d_memop_o),
		.d_mulop_o             (d_mulop_o),
		.d_branchcond_o        (d_branchcond_o),
		.d_addr_offs_o         (d_addr_offs_o),
		.d_addr_is_regoffs_o   (d_addr_is_regoffs_o),
		.d_except_o            (d_except_o)
	);

	always #4 clk = ~clk;

	// ------------------------------------------------------------
	// random stimulus

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'((lcg_next() >> 16) % n);
	endfunction

	// one instruction of the given class with random fields, class 11 is a raw word
	function automatic logic [31:0] rand_instr(input int cls);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm12;
		logic [19:0] imm20;
		int          idx;
		rd    = 5'(rand_below(32));
		rs1   = 5'(rand_below(32));
		rs2   = 5'(rand_below(32));
		f3    = 3'(rand_below(8));
		imm12 = 12'(lcg_next() >> 8);
		imm20 = 20'(lcg_next() >> 4);
		case (cls)
			0: begin
				idx = rand_below(5);
				f3  = 3'(idx < 3 ? idx : idx + 1);
				return {imm12, rs1, f3, rd, 7'b0000011};
			end
			1: return {imm12[11:5], rs2, rs1, 3'(rand_below(3)), imm12[4:0], 7'b0100011};
			2: begin
				idx = rand_below(6);
				f3  = 3'(idx < 2 ? idx : idx + 2);
				return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b1100011};
			end
			3: return {imm20, rd, 7'b1101111};
			4: return {imm12, rs1, 3'b000, rd, 7'b1100111};
			5: begin
				if (f3 == 3'b001)
					imm12[11:5] = 7'h00;
				if (f3 == 3'b101)
					imm12[11:5] = rand_below(2) != 0 ? 7'h20 : 7'h00;
				return {imm12, rs1, f3, rd, 7'b0010011};
			end
			6: begin
				case (rand_below(3))
					0: f7 = 7'h00;
					1: begin
						f7 = 7'h20;
						f3 = rand_below(2) != 0 ? 3'b101 : 3'b000;
					end
					default: f7 = 7'h01;
				endcase
				return {f7, rs2, rs1, f3, rd, 7'b0110011};
			end
			7: return {imm20, rd, 7'b0110111};
			8: return {imm20, rd, 7'b0010111};
			9: return {imm12, rs1, 3'b000, rd, 7'b0001111};
			10: begin
				case (rand_below(3))
					0: return 32'h0000_0073;
					1: return 32'h0010_0073;
					default: return 32'h3020_0073;
				endcase
			end
			default: return lcg_next();
		endcase
	endfunction

	// ------------------------------------------------------------
	// reference decode

	function automatic void ref_decode(input logic [31:0] ins, input logic mmode,
			input logic starved, input logic fault, input logic locked);
		logic [4:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic        legal;
		opc   = ins[6:2];
		f3    = ins[14:12];
		f7    = ins[31:25];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		legal       = ins[1:0] == 2'b11;
		exp_rs1     = ins[19:15];
		exp_rs2     = ins[24:20];
		exp_rd      = ins[11:7];
		exp_imm     = imm_i;
		exp_offs    = 32'd0;
		exp_src_a   = ALUSRCA_RS1;
		exp_src_b   = ALUSRCB_RS2;
		exp_aluop   = ALUOP_ADD;
		exp_memop   = MEMOP_NONE;
		exp_mulop   = M_OP_MUL;
		exp_bcond   = BCOND_NEVER;
		exp_regoffs = 1'b0;
		exp_except  = EXCEPT_NONE;
		case (opc)
			OPC_BRANCH: begin
				exp_rd   = 5'd0;
				exp_offs = imm_b;
				if (f3 == 3'd2 || f3 == 3'd3)
					legal = 1'b0;
				exp_aluop = f3[2] == 1'b0 ? ALUOP_SUB : (f3[1] ? ALUOP_LTU : ALUOP_LT);
				// BEQ, BGE and BGEU take the branch on a zero ALU result
				if (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7)
					exp_bcond = BCOND_ZERO;
				else
					exp_bcond = BCOND_NZERO;
			end
			OPC_JAL, OPC_JALR: begin
				exp_bcond = BCOND_ALWAYS;
				exp_src_a = ALUSRCA_PC;
				exp_src_b = ALUSRCB_IMM;
				exp_imm   = 32'd4;
				exp_rs2   = 5'd0;
				if (opc == OPC_JAL) begin
					exp_rs1  = 5'd0;
					exp_offs = imm_j;
				end else begin
					exp_regoffs = 1'b1;
					exp_offs    = imm_i;
					legal       = legal && f3 == 3'd0;
				end
			end
			OPC_LUI, OPC_AUIPC: begin
				exp_imm   = imm_u;
				exp_src_b = ALUSRCB_IMM;
				exp_rs1   = 5'd0;
				exp_rs2   = 5'd0;
				if (opc == OPC_LUI)
					exp_aluop = ALUOP_RS2;
				else
					exp_src_a = ALUSRCA_PC;
			end
			OPC_LOAD: begin
				exp_regoffs = 1'b1;
				exp_rs2     = 5'd0;
				exp_offs    = imm_i;
				case (f3)
					3'd0: exp_memop = MEMOP_LB;
					3'd1: exp_memop = MEMOP_LH;
					3'd2: exp_memop = MEMOP_LW;
					3'd4: exp_memop = MEMOP_LBU;
					3'd5: exp_memop = MEMOP_LHU;
					default: legal = 1'b0;
				endcase
			end
			OPC_STORE: begin
				exp_regoffs = 1'b1;
				exp_aluop   = ALUOP_RS2;
				exp_rd      = 5'd0;
				exp_offs    = imm_s;
				case (f3)
					3'd0: exp_memop = MEMOP_SB;
					3'd1: exp_memop = MEMOP_SH;
					3'd2: exp_memop = MEMOP_SW;
					default: legal = 1'b0;
				endcase
			end
			OPC_OP_IMM, OPC_OP: begin
				if (opc == OPC_OP_IMM) begin
					exp_src_b = ALUSRCB_IMM;
					exp_rs2   = 5'd0;
				end
				case (f3)
					3'd0: exp_aluop = ALUOP_ADD;
					3'd1: exp_aluop = ALUOP_SLL;
					3'd2: exp_aluop = ALUOP_LT;
					3'd3: exp_aluop = ALUOP_LTU;
					3'd4: exp_aluop = ALUOP_XOR;
					3'd5: exp_aluop = f7 == 7'h20 ? ALUOP_SRA : ALUOP_SRL;
					3'd6: exp_aluop = ALUOP_OR;
					default: exp_aluop = ALUOP_AND;
				endcase
				if (opc == OPC_OP_IMM) begin
					if (f3 == 3'd1)
						legal = legal && f7 == 7'h00;
					if (f3 == 3'd5)
						legal = legal && (f7 == 7'h00 || f7 == 7'h20);
				end else if (f7 == 7'h01) begin
					exp_aluop = ALUOP_MULDIV;
					exp_mulop = mulop_e'(f3);
				end else if (f7 == 7'h20) begin
					legal     = legal && (f3 == 3'd0 || f3 == 3'd5);
					exp_aluop = f3 == 3'd0 ? ALUOP_SUB : ALUOP_SRA;
				end else if (f7 != 7'h00) begin
					legal = 1'b0;
				end
			end
			OPC_MISC_MEM: begin
				exp_rs2 = 5'd0;
				legal   = legal && f3 == 3'd0;
			end
			OPC_SYSTEM: begin
				exp_rs1 = 5'd0;
				exp_rs2 = 5'd0;
				exp_rd  = 5'd0;
				if (ins == 32'h0000_0073)
					exp_except = mmode ? EXCEPT_ECALL_M : EXCEPT_ECALL_U;
				else if (ins == 32'h0010_0073)
					exp_except = EXCEPT_EBREAK;
				else if (ins == 32'h3020_0073 && mmode)
					exp_except = EXCEPT_MRET;
				else
					legal = 1'b0;
			end
			default: legal = 1'b0;
		endcase
		if (!legal || starved || fault) begin
			exp_rs1     = 5'd0;
			exp_rs2     = 5'd0;
			exp_rd      = 5'd0;
			exp_memop   = MEMOP_NONE;
			exp_bcond   = BCOND_NEVER;
			exp_regoffs = 1'b1;
			exp_aluop   = ALUOP_ADD;
			if (fault)
				exp_except = EXCEPT_INSTR_FAULT;
			else if (!legal && !starved)
				exp_except = EXCEPT_INSTR_ILLEGAL;
			else
				exp_except = EXCEPT_NONE;
		end
		if (locked)
			exp_bcond = BCOND_NEVER;
	endfunction

	// ------------------------------------------------------------
	// checking

	task automatic check_field(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// compares the current cycle and then advances the PC and lock model
	task automatic check_cycle();
		logic        starved;
		logic        fault;
		logic        stall;
		logic        lock_now;
		starved  = fd_cir_vld_i < 2'd2;
		fault    = !starved && fd_cir_err_i != 2'b00;
		stall    = x_stall_i || starved;
		lock_now = f_jump_now_i && x_jump_not_except_i && stall;
		check_field("d_pc_o", d_pc_o, exp_pc);
		check_field("df_cir_use_o", df_cir_use_o, stall ? 32'd0 : 32'd2);
		check_field("df_cir_flush_behind_o", df_cir_flush_behind_o, lock_now && !exp_lock);
		check_field("d_starved_o", d_starved_o, starved);
		ref_decode(fd_cir_i, m_mode_i, starved, fault, exp_lock);
		check_field("d_rs1_o", d_rs1_o, exp_rs1);
		check_field("d_rs2_o", d_rs2_o, exp_rs2);
		check_field("d_rd_o", d_rd_o, exp_rd);
		check_field("d_imm_o", d_imm_o, exp_imm);
		check_field("d_funct3_o", d_funct3_o, fd_cir_i[14:12]);
		check_field("d_funct7_o", d_funct7_o, fd_cir_i[31:25]);
		check_field("d_alusrc_a_o", d_alusrc_a_o, exp_src_a);
		check_field("d_alusrc_b_o", d_alusrc_b_o, exp_src_b);
		check_field("d_aluop_o", d_aluop_o, exp_aluop);
		check_field("d_memop_o", d_memop_o, exp_memop);
		check_field("d_mulop_o", d_mulop_o, exp_mulop);
		check_field("d_branchcond_o", d_branchcond_o, exp_bcond);
		check_field("d_addr_offs_o", d_addr_offs_o, exp_offs);
		check_field("d_addr_is_regoffs_o", d_addr_is_regoffs_o, exp_regoffs);
		check_field("d_except_o", d_except_o, exp_except);

		// a trap redirect is taken at once, a decode jump under stall waits for release
		if (f_jump_now_i && !lock_now)
			exp_pc = f_jump_target_i;
		else if (exp_lock && !stall)
			exp_pc = f_jump_target_i;
		else if (!stall)
			exp_pc = exp_pc + 32'd4;
		exp_lock = (exp_lock && stall) || lock_now;
	endtask

	task automatic run_cycle(input logic [31:0] instr, input logic [1:0] vld,
			input logic [1:0] err, input logic stall, input logic jump,
			input logic [31:0] target, input logic jne, input logic mmode);
		@(posedge clk);
		fd_cir_i            <= instr;
		fd_cir_vld_i        <= vld;
		fd_cir_err_i        <= err;
		x_stall_i           <= stall;
		f_jump_now_i        <= jump;
		f_jump_target_i     <= target;
		x_jump_not_except_i <= jne;
		m_mode_i            <= mmode;
		@(negedge clk);
		check_cycle();
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// keeps the target presented until decode consumes the locked instruction
	task automatic wait_for_release(input logic [31:0] instr, input logic [31:0] target);
		int cycles;
		cycles = 0;
		do begin
			run_cycle(instr, 2'd2, 2'b00, 1'b0, 1'b0, target, 1'b1, 1'b1);
			cycles++;
		end while (df_cir_use_o !== 2'd2 && cycles < RELEASE_TIMEOUT);
		if (df_cir_use_o !== 2'd2) begin
			timeout_count++;
			$display("timeout: decode did not consume the locked instruction in %0d cycles",
				RELEASE_TIMEOUT);
		end
	endtask

	// ------------------------------------------------------------
	// test sequence

	initial begin
		int k;
		int hold;
		clk                 = 1'b0;
		rst_n               = 1'b0;
		fd_cir_i            = NOP;
		fd_cir_vld_i        = 2'd0;
		fd_cir_err_i        = 2'b00;
		x_stall_i           = 1'b0;
		f_jump_now_i        = 1'b0;
		f_jump_target_i     = 32'd0;
		x_jump_not_except_i = 1'b0;
		m_mode_i            = 1'b1;
		exp_pc              = RESET_VECTOR;
		exp_lock            = 1'b0;
		lcg_state           = 32'd84449;
		mismatch_count      = 0;
		timeout_count       = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// reset state, then plain flow
		run_cycle(NOP, 2'd0, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		for (k = 0; k < 8; k++)
			run_cycle(rand_instr(rand_below(11)), 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);

		// starvation and execute stall both hold the PC
		run_cycle(BEQ_FWD, 2'd1, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(rand_instr(0), 2'd0, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(rand_instr(1), 2'd2, 2'b00, 1'b1, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(rand_instr(6), 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);

		// random decode table
		for (k = 0; k < 400; k++) begin
			run_cycle(rand_instr(rand_below(12)),
				rand_below(10) == 0 ? 2'(rand_below(2)) : 2'd2,
				rand_below(16) == 0 ? 2'(1 + rand_below(3)) : 2'b00,
				rand_below(8) == 0, 1'b0, 32'd0, 1'b0, rand_below(2) != 0);
		end

		// illegal words and exceptions
		run_cycle(32'h0000_007f, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(32'h0000_4501, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(32'h3020_0073, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0);
		run_cycle(32'h3020_0073, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(32'h0000_0073, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(32'h0000_0073, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0);
		run_cycle(32'h0010_0073, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b0);
		run_cycle(32'h0000_007f, 2'd2, 2'b01, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(32'h0000_007f, 2'd2, 2'b10, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(32'h0000_007f, 2'd1, 2'b01, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);

		// unstalled jump, then a trap redirect during a stall
		run_cycle(rand_instr(3), 2'd2, 2'b00, 1'b0, 1'b1, 32'h0000_2000, 1'b1, 1'b1);
		run_cycle(NOP, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
		run_cycle(NOP, 2'd2, 2'b00, 1'b1, 1'b1, 32'h0000_2800, 1'b0, 1'b1);
		run_cycle(NOP, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);

		// CIR lock under an execute stall, then under starvation
		for (k = 0; k < 2; k++) begin
			run_cycle(BEQ_FWD, k == 0 ? 2'd2 : 2'd1, 2'b00, k == 0, 1'b1,
				32'h0000_3000 + 32'(k * 'h100), 1'b1, 1'b1);
			check_field("flush pulse on lock", df_cir_flush_behind_o, 1'b1);
			hold = 2 + rand_below(3);
			while (hold > 0) begin
				// a second decode jump while locked must not pulse again
				run_cycle(BEQ_FWD, 2'd2, 2'b00, 1'b1, hold == 2,
					32'h0000_3000 + 32'(k * 'h100), 1'b1, 1'b1);
				check_field("branch condition while locked", d_branchcond_o, BCOND_NEVER);
				check_field("flush while locked", df_cir_flush_behind_o, 1'b0);
				hold--;
			end
			wait_for_release(BEQ_FWD, 32'h0000_3000 + 32'(k * 'h100));
			run_cycle(NOP, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0, 1'b0, 1'b1);
			check_field("PC after lock release", d_pc_o, 32'h0000_3000 + 32'(k * 'h100));
		end

		finish_run();
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/rv_decode_pkg.sv
verilog/rv_imm_gen.sv
verilog/rv_op_decode.sv
verilog/rv_pc_ctrl.sv
verilog/rv_decode_top.sv
dv/tb_rv_decode.sv
